//--- common/ucode_pkg.sv
`default_nettype none

package ucode_pkg;

    // one-hot sequencer states.
    typedef enum logic [6:0] {
        st_start     = 7'b000_0001,
        st_read_src1 = 7'b000_0010,
        st_read_src2 = 7'b000_0100,
        st_calc      = 7'b000_1000,
        st_wait      = 7'b001_0000,
        st_write     = 7'b010_0000,
        st_done      = 7'b100_0000
    } seq_state_t;

    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_cubic = 2'd2,
        op_mult  = 2'd3
    } op_t;

    typedef logic [5:0] ram_addr_t;

    // calc length, zero means halt.
    typedef logic [8:0] times_t;

    // 29-bit microinstruction as stored in the program ROM.
    typedef struct packed {
        ram_addr_t dest;
        ram_addr_t src1;
        op_t       op;
        times_t    times;
        ram_addr_t src2;
    } micro_instr_t;

endpackage

`default_nettype wire

//--- common/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

    // single-cycle enables for the processing element.
    typedef struct packed {
        logic ld_x;
        logic ld_y;
        logic ld_ry;
        logic clr_acc;
        logic acc_from_x;
        logic add_en;
        logic sub_en;
        logic mul_step;
        logic cube_step;
        logic shift_y;
        logic res_sel_en;
    } pe_ctrl_t;

    typedef enum logic {
        res_acc = 1'b0,
        res_x   = 1'b1
    } res_sel_t;

endpackage

`default_nettype wire

//--- hw/program_rom.sv
`default_nettype none

module program_rom
    import ucode_pkg::*;
#(
    parameter int rom_aw = 5
)
(
    input  logic              clk,
    input  logic [rom_aw-1:0] addr,
    output micro_instr_t      q
);

    logic [$bits(micro_instr_t)-1:0] mem [2**rom_aw];

    initial
    begin
        $readmemh("program.mem", mem);
    end

    // registered read, one cycle behind addr.
    always_ff @(posedge clk)
    begin
        q <= micro_instr_t'(mem[addr]);
    end

endmodule

`default_nettype wire

//--- sequencer/micro_sequencer.sv
`default_nettype none

module micro_sequencer
    import ucode_pkg::*;
    import datapath_pkg::*;
#(
    parameter int          rom_aw      = 5,
    parameter int unsigned loop1_start = 0,
    parameter int unsigned loop1_end   = 0,
    parameter int unsigned loop1_count = 0,
    parameter int unsigned loop2_start = 0,
    parameter int unsigned loop2_end   = 0,
    parameter int unsigned loop2_count = 0
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic [rom_aw-1:0] rom_addr,
    input  micro_instr_t      rom_q,
    output ram_addr_t         ram_a_addr,
    output ram_addr_t         ram_b_addr,
    output logic              ram_b_w,
    output pe_ctrl_t          pe,
    output logic              done
);

    localparam int unsigned max_count =
        (loop1_count > loop2_count) ? loop1_count : loop2_count;
    localparam int lc_w = $clog2(max_count + 1) + 1;

    localparam int unsigned loop_start [2] = '{loop1_start, loop2_start};
    localparam int unsigned loop_end [2]   = '{loop1_end, loop2_end};
    localparam int unsigned loop_count [2] = '{loop1_count, loop2_count};

    seq_state_t      state;
    times_t          calc_left;
    logic [lc_w-1:0] loop_left [2];
    logic [1:0]      loop_take;
    logic            launch;
    logic            halt;
    pe_ctrl_t        pe_next;

    assign launch = start && (state == st_start || state == st_done);
    assign halt = rom_q.times == '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_start;
        end
        else
        begin
            case (state)
                st_start, st_done:
                begin
                    if (start)
                        state <= st_read_src1;
                end
                st_read_src1:
                    state <= st_read_src2;
                st_read_src2:
                    state <= halt ? st_done : st_calc;
                st_calc:
                begin
                    if (calc_left == times_t'(1))
                        state <= st_wait;
                end
                st_wait:
                    state <= st_write;
                st_write:
                    state <= st_read_src1;
                default:
                    state <= st_start;
            endcase
        end
    end

    // calc length, loaded while src1 is read.
    always_ff @(posedge clk)
    begin
        if (reset)
            calc_left <= '0;
        else if (state == st_read_src1)
            calc_left <= rom_q.times;
        else if (state == st_calc)
            calc_left <= calc_left - 1'b1;
    end

    // repeats left per hardware loop.
    for (genvar i = 0; i < 2; i++)
    begin : g_loop
        assign loop_take[i] = state == st_wait && loop_left[i] != '0
                              && rom_addr == rom_aw'(loop_end[i]);

        always_ff @(posedge clk)
        begin
            if (reset || launch)
                loop_left[i] <= lc_w'(loop_count[i]);
            else if (loop_take[i])
                loop_left[i] <= loop_left[i] - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || launch)
            rom_addr <= '0;
        else if (state == st_read_src2 && halt)
            // park on 0 so the rom already holds the first word at restart.
            rom_addr <= '0;
        else if (state == st_wait)
        begin
            if (loop_take[0])
                rom_addr <= rom_aw'(loop_start[0]);
            else if (loop_take[1])
                rom_addr <= rom_aw'(loop_start[1]);
            else
                rom_addr <= rom_addr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= state == st_done && !start;
    end

    always_comb
    begin
        ram_a_addr = '0;
        ram_b_addr = '0;
        case (state)
            st_read_src1:
            begin
                ram_a_addr = rom_q.src1;
                ram_b_addr = rom_q.src2;
            end
            st_read_src2:
            begin
                ram_a_addr = rom_q.src2;
                ram_b_addr = rom_q.src2;
            end
            st_write:
                ram_b_addr = rom_q.dest;
            default:
                ;
        endcase
    end

    assign ram_b_w = state == st_write;

    // enables act one cycle after the state that produced them.
    always_comb
    begin
        pe_next = '0;
        case (state)
            st_read_src1:
            begin
                pe_next.ld_x = 1'b1;
                if (rom_q.op == op_mult)
                begin
                    pe_next.ld_ry = 1'b1;
                    pe_next.clr_acc = 1'b1;
                end
            end
            st_read_src2:
            begin
                case (rom_q.op)
                    op_add, op_sub:
                        pe_next.ld_y = 1'b1;
                    op_cubic:
                        pe_next.acc_from_x = 1'b1;
                    default:
                        ;
                endcase
            end
            st_calc:
            begin
                pe_next.res_sel_en = 1'b1;
                case (rom_q.op)
                    op_add:
                        pe_next.add_en = 1'b1;
                    op_sub:
                        pe_next.sub_en = 1'b1;
                    op_mult:
                    begin
                        pe_next.mul_step = 1'b1;
                        pe_next.shift_y = 1'b1;
                    end
                    op_cubic:
                        pe_next.cube_step = 1'b1;
                endcase
            end
            default:
                ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pe <= '0;
        else
            pe <= pe_next;
    end

endmodule

`default_nettype wire

//--- hw/data_ram.sv
`default_nettype none

module data_ram
    import ucode_pkg::*;
#(
    parameter int word_w = 16
)
(
    input  logic              clk,
    input  ram_addr_t         ram_a_addr,
    input  ram_addr_t         ram_b_addr,
    input  logic              ram_b_w,
    input  logic [word_w-1:0] wdata,
    output logic [word_w-1:0] ram_a_q,
    output logic [word_w-1:0] ram_b_q,
    input  logic              host_we,
    input  ram_addr_t         host_addr,
    input  logic [word_w-1:0] host_wdata,
    output logic [word_w-1:0] host_rdata
);

    logic [word_w-1:0] mem [64];

    // the host owns the write port whenever it writes.
    always_ff @(posedge clk)
    begin
        if (host_we)
            mem[host_addr] <= host_wdata;
        else if (ram_b_w)
            mem[ram_b_addr] <= wdata;
    end

    always_ff @(posedge clk)
    begin
        ram_a_q <= mem[ram_a_addr];
        ram_b_q <= mem[ram_b_addr];
    end

    always_ff @(posedge clk)
    begin
        host_rdata <= mem[host_addr];
    end

endmodule

`default_nettype wire

//--- pe_array/pe_array.sv
`default_nettype none

module pe_array
    import datapath_pkg::*;
#(
    parameter int word_w = 16
)
(
    input  logic              clk,
    input  logic              reset,
    input  pe_ctrl_t          pe,
    input  logic [word_w-1:0] ram_a_q,
    input  logic [word_w-1:0] ram_b_q,
    output logic [word_w-1:0] result
);

    logic [word_w-1:0] x;
    logic [word_w-1:0] y;
    logic [word_w-1:0] acc;
    logic [word_w-1:0] x_sq;
    logic [word_w-1:0] x_cube;
    logic [word_w-1:0] partial;
    res_sel_t          res_sel;

    // products wrap at word_w bits.
    assign x_sq = x * x;
    assign x_cube = x_sq * x;

    // shift-and-add term for the current multiplier bit.
    assign partial = y[0] ? x : '0;

    always_ff @(posedge clk)
    begin
        if (pe.ld_x)
            x <= ram_a_q;
        else if (pe.cube_step)
            x <= x_cube;
        else if (pe.mul_step)
            x <= x << 1;
    end

    always_ff @(posedge clk)
    begin
        if (pe.ld_y)
            y <= ram_a_q;
        else if (pe.ld_ry)
            y <= ram_b_q;
        else if (pe.shift_y)
            y <= y >> 1;
    end

    always_ff @(posedge clk)
    begin
        if (pe.clr_acc)
            acc <= '0;
        else if (pe.acc_from_x)
            acc <= x;
        else if (pe.add_en)
            acc <= x + y;
        else if (pe.sub_en)
            acc <= x - y;
        else if (pe.mul_step)
            acc <= acc + partial;
    end

    // cubic leaves its answer in x, the other ops in acc.
    always_ff @(posedge clk)
    begin
        if (reset)
            res_sel <= res_acc;
        else if (pe.res_sel_en)
            res_sel <= pe.cube_step ? res_x : res_acc;
    end

    assign result = (res_sel == res_x) ? x : acc;

endmodule

`default_nettype wire

//--- hw/ecc_core.sv
`default_nettype none

module ecc_core
    import ucode_pkg::*;
    import datapath_pkg::*;
#(
    parameter int          word_w      = 16,
    parameter int          rom_aw      = 5,
    parameter int unsigned loop1_start = 4,
    parameter int unsigned loop1_end   = 5,
    parameter int unsigned loop1_count = 2,
    parameter int unsigned loop2_start = 9,
    parameter int unsigned loop2_end   = 10,
    parameter int unsigned loop2_count = 3
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              host_we,
    input  ram_addr_t         host_addr,
    input  logic [word_w-1:0] host_wdata,
    output logic [word_w-1:0] host_rdata,
    output logic              done
);

    logic [rom_aw-1:0] rom_addr;
    micro_instr_t      rom_q;
    ram_addr_t         ram_a_addr;
    ram_addr_t         ram_b_addr;
    logic              ram_b_w;
    pe_ctrl_t          pe;
    logic [word_w-1:0] ram_a_q;
    logic [word_w-1:0] ram_b_q;
    logic [word_w-1:0] result;

    program_rom #(
        .rom_aw(rom_aw)
    ) u_rom (
        .clk (clk),
        .addr(rom_addr),
        .q   (rom_q)
    );

    micro_sequencer #(
        .rom_aw     (rom_aw),
        .loop1_start(loop1_start),
        .loop1_end  (loop1_end),
        .loop1_count(loop1_count),
        .loop2_start(loop2_start),
        .loop2_end  (loop2_end),
        .loop2_count(loop2_count)
    ) u_seq (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rom_addr  (rom_addr),
        .rom_q     (rom_q),
        .ram_a_addr(ram_a_addr),
        .ram_b_addr(ram_b_addr),
        .ram_b_w   (ram_b_w),
        .pe        (pe),
        .done      (done)
    );

    data_ram #(
        .word_w(word_w)
    ) u_ram (
        .clk       (clk),
        .ram_a_addr(ram_a_addr),
        .ram_b_addr(ram_b_addr),
        .ram_b_w   (ram_b_w),
        .wdata     (result),
        .ram_a_q   (ram_a_q),
        .ram_b_q   (ram_b_q),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

    pe_array #(
        .word_w(word_w)
    ) u_pe (
        .clk    (clk),
        .reset  (reset),
        .pe     (pe),
        .ram_a_q(ram_a_q),
        .ram_b_q(ram_b_q),
        .result (result)
    );

endmodule

`default_nettype wire

//--- tb/ecc_core_checker.sv
`default_nettype none

module ecc_core_checker
    import ucode_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input seq_state_t   state,
    input micro_instr_t rom_q,
    input logic         ram_b_w,
    input logic         done
);

    logic [9:0] calc_cycles;

    // length of the current run of st_calc.
    always_ff @(posedge clk)
    begin
        if (reset || state != st_calc)
            calc_cycles <= '0;
        else
            calc_cycles <= calc_cycles + 1'b1;
    end

    // a write only ever follows the wait cycle.
    a_write_state: assert property (@(posedge clk) disable iff (reset)
        ram_b_w |-> $past(state) == st_wait)
        else $error("ram_b_w high without a preceding st_wait");

    a_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot(state))
        else $error("sequencer state is not one-hot");

    // wait always follows the last calc cycle.
    a_calc_length: assert property (@(posedge clk) disable iff (reset)
        state == st_wait |-> calc_cycles == {1'b0, rom_q.times})
        else $error("st_calc length differs from the instruction times field");

    a_done_state: assert property (@(posedge clk) disable iff (reset)
        done |-> state == st_done)
        else $error("done high outside st_done");

endmodule

`default_nettype wire

//--- tb/ecc_core_tb.sv
`default_nettype none

module ecc_core_tb;

    localparam int word_w = 16;
    localparam int rom_aw = 5;
    localparam int loop1_start = 4;
    localparam int loop1_end = 5;
    localparam int loop1_count = 2;
    localparam int loop2_start = 9;
    localparam int loop2_end = 10;
    localparam int loop2_count = 3;
    localparam int rows = 6;
    localparam logic [1:0] code_add = 2'd0;
    localparam logic [1:0] code_sub = 2'd1;
    localparam logic [1:0] code_cubic = 2'd2;

    logic              clk;
    logic              reset;
    logic              start;
    logic              host_we;
    logic [5:0]        host_addr;
    logic [word_w-1:0] host_wdata;
    logic [word_w-1:0] host_rdata;
    logic              done;

    logic [28:0]       rom_image [2**rom_aw];
    logic [word_w-1:0] model_ram [64];
    logic              written [64];
    logic [word_w-1:0] row_a [rows];
    logic [word_w-1:0] row_b [rows];
    logic [word_w-1:0] row_expect [rows][64];
    logic [15:0]       lfsr;
    int                cycle_count = 0;
    int                timeout_limit = 0;

    ecc_core #(
        .word_w     (word_w),
        .rom_aw     (rom_aw),
        .loop1_start(loop1_start),
        .loop1_end  (loop1_end),
        .loop1_count(loop1_count),
        .loop2_start(loop2_start),
        .loop2_end  (loop2_end),
        .loop2_count(loop2_count)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .done      (done)
    );

    bind micro_sequencer ecc_core_checker u_checker (
        .clk    (clk),
        .reset  (reset),
        .state  (state),
        .rom_q  (rom_q),
        .ram_b_w(ram_b_w),
        .done   (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit)
        begin
            $display("timeout after %0d cycles, done never rose", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input string name, input logic [word_w-1:0] expected,
                         input logic [word_w-1:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_word(output logic [word_w-1:0] w);
        for (int i = 0; i < word_w; i++)
        begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    function automatic logic [word_w-1:0] shift_add_mult(input logic [word_w-1:0] x,
                                                         input logic [word_w-1:0] y,
                                                         input int steps);
        logic [word_w-1:0] sum;
        sum = '0;
        for (int i = 0; i < steps && i < word_w; i++)
        begin
            if (y[i])
                sum = sum + (x << i);
        end
        return sum;
    endfunction

    function automatic logic [word_w-1:0] repeated_cube(input logic [word_w-1:0] x,
                                                        input int rounds);
        logic [word_w-1:0] v;
        v = x;
        for (int i = 0; i < rounds; i++)
            v = v * v * v;
        return v;
    endfunction

    // instruction-set interpreter over the model ram.
    task automatic run_model(input logic [word_w-1:0] a, input logic [word_w-1:0] b,
                             output int cycles);
        int                pc;
        int                left1;
        int                left2;
        int                steps;
        int                times;
        logic              halted;
        logic [28:0]       w;
        logic [word_w-1:0] x;
        logic [word_w-1:0] y;
        logic [word_w-1:0] r;
        foreach (model_ram[i])
            model_ram[i] = '0;
        model_ram[1] = a;
        model_ram[2] = b;
        pc = 0;
        left1 = loop1_count;
        left2 = loop2_count;
        steps = 0;
        cycles = 2;
        halted = 1'b0;
        while (!halted)
        begin
            w = rom_image[pc];
            times = int'(w[14:6]);
            steps++;
            if (steps > 1000)
            begin
                $display("reference model never reached a halt instruction");
                $display("STATUS: FAIL");
                $fatal(1, "model runaway");
            end
            if (times == 0)
            begin
                cycles += 5;
                halted = 1'b1;
            end
            else
            begin
                x = model_ram[w[22:17]];
                y = model_ram[w[5:0]];
                case (w[16:15])
                    code_add:
                        r = x + y;
                    code_sub:
                        r = x - y;
                    code_cubic:
                        r = repeated_cube(x, times);
                    default:
                        r = shift_add_mult(x, y, times);
                endcase
                model_ram[w[28:23]] = r;
                written[w[28:23]] = 1'b1;
                cycles += times + 4;
                if (pc == loop1_end && left1 > 0)
                begin
                    pc = loop1_start;
                    left1--;
                end
                else if (pc == loop2_end && left2 > 0)
                begin
                    pc = loop2_start;
                    left2--;
                end
                else
                    pc++;
            end
        end
    endtask

    task automatic host_write(input logic [5:0] addr, input logic [word_w-1:0] data);
        @(posedge clk);
        host_we <= 1'b1;
        host_addr <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic host_read(input logic [5:0] addr, output logic [word_w-1:0] data);
        @(posedge clk);
        host_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic run_program(input string label);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check({label, " done low after start"}, '0, done);
        while (!done)
            @(negedge clk);
    endtask

    task automatic check_results(input int row, input string label);
        logic [word_w-1:0] got;
        for (int addr = 0; addr < 64; addr++)
        begin
            if (written[addr])
            begin
                host_read(6'(addr), got);
                check($sformatf("%s row %0d addr %0d", label, row, addr),
                      row_expect[row][addr], got);
            end
        end
    endtask

    initial
    begin
        logic [word_w-1:0] got;
        int                prog_cycles;
        int                dest_count;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        lfsr = 16'd14757;

        // zero, all ones, one, and a pair that wraps the sign bit.
        row_a[0] = 16'h0000;
        row_b[0] = 16'h1234;
        row_a[1] = 16'hffff;
        row_b[1] = 16'hffff;
        row_a[2] = 16'h0001;
        row_b[2] = 16'h0003;
        row_a[3] = 16'h7fff;
        row_b[3] = 16'h8001;
        for (int r = 4; r < rows; r++)
        begin
            draw_word(row_a[r]);
            draw_word(row_b[r]);
        end

        foreach (rom_image[i])
            rom_image[i] = '0;
        $readmemh("program.mem", rom_image);
        foreach (written[i])
            written[i] = 1'b0;
        prog_cycles = 0;
        for (int r = 0; r < rows; r++)
        begin
            run_model(row_a[r], row_b[r], prog_cycles);
            for (int i = 0; i < 64; i++)
                row_expect[r][i] = model_ram[i];
        end
        dest_count = 0;
        foreach (written[i])
        begin
            if (written[i])
                dest_count++;
        end
        timeout_limit = rows * (2 * prog_cycles + 8 + 6 * dest_count) + 100;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("done low after reset", '0, done);
        host_write(6'd63, 16'hc35a);
        host_read(6'd63, got);
        check("host write then read", 16'hc35a, got);

        for (int r = 0; r < rows; r++)
        begin
            host_write(6'd1, row_a[r]);
            host_write(6'd2, row_b[r]);
            run_program($sformatf("row %0d first run", r));
            check_results(r, "first run");
            // restart from address 0 with rearmed loops.
            run_program($sformatf("row %0d rerun", r));
            check_results(r, "rerun");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- program.mem
// one 29-bit microinstruction per line in hex, fields dest[28:23] src1[22:17] op[16:15]
// times[14:6] src2[5:0]; op 0 add, 1 sub, 2 cubic, 3 mult; times 0 halts
01820042
02028042
02848081
03820042
// loop1 body, addresses 4 and 5
038E0043
040F8401
04838142
05030041
05888041
// loop2 body, addresses 9 and 10
059680C2
0617008B
0698004B
07058501
079500CA
0812004E
08A0804D
00000000

//--- ecc_core.f
common/ucode_pkg.sv
common/datapath_pkg.sv
hw/program_rom.sv
sequencer/micro_sequencer.sv
hw/data_ram.sv
pe_array/pe_array.sv
hw/ecc_core.sv
tb/ecc_core_checker.sv
tb/ecc_core_tb.sv

//--- Bender.yml
package:
  name: ecc_core

sources:
  - common/ucode_pkg.sv
  - common/datapath_pkg.sv
  - hw/program_rom.sv
  - sequencer/micro_sequencer.sv
  - hw/data_ram.sv
  - pe_array/pe_array.sv
  - hw/ecc_core.sv
  - target: test
    files:
      - tb/ecc_core_checker.sv
      - tb/ecc_core_tb.sv
